// ==== imem.hex ====
// One 32-bit instruction word per line, word address 0 to 63 (addi x1, x0, address).
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00A00093
00B00093
00C00093
00D00093
00E00093
00F00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01A00093
01B00093
01C00093
01D00093
01E00093
01F00093
02000093
02100093
02200093
02300093
02400093
02500093
02600093
02700093
02800093
02900093
02A00093
02B00093
02C00093
02D00093
02E00093
02F00093
03000093
03100093
03200093
03300093
03400093
03500093
03600093
03700093
03800093
03900093
03A00093
03B00093
03C00093
03D00093
03E00093
03F00093

// ==== list.f ====
fetchPkg.sv
memReadIf.sv
programCounter.sv
iCache.sv
instructionMemory.sv
fetchStage.sv
fetch_assertions.sv
tb_fetchStage.sv

// ==== run.sh ====
#!/bin/sh
# Build the fetch stage testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetchStage \
   -f list.f -o fetchSim
simOutput=$(./obj_dir/fetchSim 2>&1 || true)
echo "$simOutput"
if echo "$simOutput" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
exit 1

// ==== tb_fetchStage.sv ====
`default_nettype none

module tb_fetchStage;

   localparam int RANDOM_CYCLES = 600;
   localparam int WAIT_LIMIT    = 40;

   logic           clk;
   logic           rst;
   logic           PCSrcE;
   fetchPkg::wordT PCTargetE;
   logic           StallF;
   logic           StallD;
   logic           FlushD;
   fetchPkg::wordT InstrD;
   fetchPkg::wordT PCD;
   fetchPkg::wordT PCPlus4D;
   logic           ValidD;
   logic           CacheStall;

   // Reference copy of the program image.
   fetchPkg::wordT imemModel [fetchPkg::IMEM_WORDS];
   logic           checking = 1'b0;
   int             acceptCount = 0;

   fetchStage dut_i (
      .clk        (clk),
      .rst        (rst),
      .PCSrcE     (PCSrcE),
      .PCTargetE  (PCTargetE),
      .StallF     (StallF),
      .StallD     (StallD),
      .FlushD     (FlushD),
      .InstrD     (InstrD),
      .PCD        (PCD),
      .PCPlus4D   (PCPlus4D),
      .ValidD     (ValidD),
      .CacheStall (CacheStall)
   );

   bind fetchStage fetchAssertions assertChecks (
      .clk        (clk),
      .rst        (rst),
      .memRead    (memBus.memRead),
      .memReady   (memBus.memReady),
      .memAddr    (memBus.memAddr),
      .FlushD     (FlushD),
      .ValidD     (ValidD),
      .CacheStall (CacheStall),
      .cacheState (cacheUnit.state),
      .pc         (PCF)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   // Word at (PC / 4) modulo the memory depth.
   function automatic fetchPkg::wordT expectedInstr(input fetchPkg::wordT pc);
      return imemModel[int'((pc / 4) % fetchPkg::IMEM_WORDS)];
   endfunction

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic checkValue(input string name, input fetchPkg::wordT actual,
                             input fetchPkg::wordT expected);
      if (actual !== expected) begin
         reportFailure($sformatf("CHECK FAILED: %s is %h, expected %h", name, actual, expected));
      end
   endtask

   // Redirect with a flush, as the execute stage does on a taken branch.
   task automatic redirectTo(input fetchPkg::wordT target);
      @(negedge clk);
      PCSrcE    = 1'b1;
      FlushD    = 1'b1;
      PCTargetE = target;
      StallF    = 1'b0;
      StallD    = 1'b0;
      @(negedge clk);
      PCSrcE = 1'b0;
      FlushD = 1'b0;
   endtask

   task automatic waitValidAt(input fetchPkg::wordT pc, output logic sawStall);
      int cycles;
      cycles   = 0;
      sawStall = 1'b0;
      while (!(ValidD && PCD == pc)) begin
         if (CacheStall) begin
            sawStall = 1'b1;
         end
         if (cycles == WAIT_LIMIT) begin
            reportFailure($sformatf("Timed out waiting for a valid word at PC %h.", pc));
         end
         cycles++;
         @(negedge clk);
      end
   endtask

   // Inputs are taken at the edge, outputs checked at the following falling edge.
   initial begin : compareProc
      fetchPkg::wordT expPc;
      fetchPkg::wordT prevInstr;
      fetchPkg::wordT prevPc;
      fetchPkg::wordT prevPcPlus4;
      logic           prevValid;
      logic           edgeChecking;
      logic           edgeFlush;
      logic           edgeStallD;
      logic           edgeCacheStall;
      logic           edgeRedirect;
      fetchPkg::wordT edgeTarget;
      expPc       = fetchPkg::PC_INITIAL;
      prevInstr   = '0;
      prevPc      = fetchPkg::PC_INITIAL;
      prevPcPlus4 = fetchPkg::PC_INITIAL + 32'd4;
      prevValid   = 1'b0;
      forever begin
         // CacheStall only moves at rising edges, so it is read half a cycle early.
         edgeCacheStall = CacheStall;
         @(posedge clk);
         edgeChecking = checking;
         edgeFlush    = FlushD;
         edgeStallD   = StallD;
         edgeRedirect = PCSrcE;
         edgeTarget   = PCTargetE;
         @(negedge clk);
         if (edgeChecking) begin
            if (edgeFlush) begin
               checkValue("ValidD", ValidD, 32'd0);
               checkValue("InstrD", InstrD, fetchPkg::NOP_INSTR);
            end else if (edgeStallD) begin
               checkValue("ValidD", ValidD, prevValid);
               checkValue("InstrD", InstrD, prevInstr);
               checkValue("PCD", PCD, prevPc);
               checkValue("PCPlus4D", PCPlus4D, prevPcPlus4);
            end else if (edgeCacheStall) begin
               checkValue("ValidD", ValidD, 32'd0);
               checkValue("InstrD", InstrD, fetchPkg::NOP_INSTR);
            end else begin
               checkValue("ValidD", ValidD, 32'd1);
               checkValue("PCD", PCD, expPc);
               checkValue("InstrD", InstrD, expectedInstr(expPc));
               checkValue("PCPlus4D", PCPlus4D, expPc + 32'd4);
               expPc = expPc + 32'd4;
               acceptCount++;
            end
            if (edgeRedirect) begin
               expPc = edgeTarget;
            end
            prevValid   = ValidD;
            prevInstr   = InstrD;
            prevPc      = PCD;
            prevPcPlus4 = PCPlus4D;
         end
      end
   end

   initial begin : stimulusProc
      int   roll;
      logic sawStall;
      void'($urandom(46160));
      $readmemh("imem.hex", imemModel);
      rst       = 1'b1;
      PCSrcE    = 1'b0;
      PCTargetE = '0;
      StallF    = 1'b0;
      StallD    = 1'b0;
      FlushD    = 1'b0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      checkValue("ValidD", ValidD, 32'd0);
      checkValue("PCD", PCD, fetchPkg::PC_INITIAL);
      checking = 1'b1;
      waitValidAt(fetchPkg::PC_INITIAL, sawStall);

      // Random hazards; a load-use stall holds fetch and decode together.
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         @(negedge clk);
         roll   = int'($urandom % 16);
         PCSrcE = 1'b0;
         FlushD = 1'b0;
         StallF = 1'b0;
         StallD = 1'b0;
         if (roll == 0) begin
            PCSrcE    = 1'b1;
            FlushD    = 1'b1;
            PCTargetE = $urandom & 32'h0000_03FC;
         end else if (roll < 5) begin
            StallF = 1'b1;
            StallD = 1'b1;
         end
      end

      // Line 0 with tag 0, then a revisit, then tag 1 at the same index.
      redirectTo(32'h0000_0000);
      waitValidAt(32'h0000_0000, sawStall);
      redirectTo(32'h0000_0008);
      waitValidAt(32'h0000_0008, sawStall);
      if (sawStall) begin
         reportFailure("The cache stalled on a line it already holds.");
      end
      redirectTo(32'h0000_0040);
      waitValidAt(32'h0000_0040, sawStall);
      if (!sawStall) begin
         reportFailure("The cache did not stall on a tag conflict at the same index.");
      end
      waitValidAt(32'h0000_0058, sawStall);
      if (acceptCount < 50) begin
         reportFailure("Too few words reached decode during the run.");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== fetch_assertions.sv ====
`default_nettype none

module fetchAssertions (
   input wire logic                 clk,
   input wire logic                 rst,
   input wire logic                 memRead,
   input wire logic                 memReady,
   input wire fetchPkg::wordT       memAddr,
   input wire logic                 FlushD,
   input wire logic                 ValidD,
   input wire logic                 CacheStall,
   input wire fetchPkg::cacheStateT cacheState,
   input wire fetchPkg::wordT       pc
);

   // Set by a request, cleared by its response.
   logic outstanding;

   // Lines returned by the memory, kept by cache index.
   fetchPkg::wordT                   requestAddr;
   fetchPkg::wordT                   filledAddr [fetchPkg::CACHE_LINES];
   logic [fetchPkg::CACHE_LINES-1:0] filled;
   fetchPkg::indexT                  requestIndex;
   fetchPkg::indexT                  pcIndex;
   logic                             lineHeld;

   assign requestIndex = requestAddr[fetchPkg::LINE_BITS +: fetchPkg::INDEX_BITS];
   assign pcIndex      = pc[fetchPkg::LINE_BITS +: fetchPkg::INDEX_BITS];
   assign lineHeld     = filled[pcIndex] &&
      (filledAddr[pcIndex][fetchPkg::WORD_SIZE-1:fetchPkg::LINE_BITS] ==
       pc[fetchPkg::WORD_SIZE-1:fetchPkg::LINE_BITS]);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         outstanding <= 1'b0;
         filled      <= '0;
      end else if (memRead) begin
         outstanding <= 1'b1;
      end else if (memReady) begin
         outstanding          <= 1'b0;
         filled[requestIndex] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (memRead) begin
         requestAddr <= memAddr;
      end
      if (memReady) begin
         filledAddr[requestIndex] <= requestAddr;
      end
   end

   readOneCycle: assert property (@(posedge clk) disable iff (rst) memRead |=> !memRead)
      else $error("memRead held for more than one cycle");

   readNotOutstanding: assert property (@(posedge clk) disable iff (rst)
      memRead |-> !outstanding)
      else $error("memRead raised while a refill is outstanding");

   readyLatency: assert property (@(posedge clk) disable iff (rst)
      memRead |-> ##(fetchPkg::MEM_LATENCY) memReady)
      else $error("memReady did not follow memRead after the memory latency");

   flushClearsValid: assert property (@(posedge clk) disable iff (rst) FlushD |=> !ValidD)
      else $error("ValidD high after a flush");

   hitNoStall: assert property (@(posedge clk) disable iff (rst)
      (cacheState == fetchPkg::IDLE && lineHeld) |-> !CacheStall)
      else $error("CacheStall high on an idle hit");

endmodule

`default_nettype wire

// ==== fetchStage.sv ====
`default_nettype none

module fetchStage (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           PCSrcE,
   input  wire fetchPkg::wordT PCTargetE,

   // From the hazard unit.
   input  wire logic           StallF,
   input  wire logic           StallD,
   input  wire logic           FlushD,

   // To decode.
   output fetchPkg::wordT      InstrD,
   output fetchPkg::wordT      PCD,
   output fetchPkg::wordT      PCPlus4D,
   output logic                ValidD,
   output logic                CacheStall
);

   fetchPkg::wordT PCF;
   fetchPkg::wordT PCPlus4F;
   fetchPkg::wordT InstrF;
   logic           pcHold;

   memReadIf memBus ();

   // The PC also waits while the cache refills.
   assign pcHold = StallF || CacheStall;

   programCounter pcUnit (
      .clk      (clk),
      .rst      (rst),
      .hold     (pcHold),
      .redirect (PCSrcE),
      .target   (PCTargetE),
      .pc       (PCF),
      .pcPlus4  (PCPlus4F)
   );

   iCache cacheUnit (
      .clk   (clk),
      .rst   (rst),
      .pc    (PCF),
      .instr (InstrF),
      .stall (CacheStall),
      .mem   (memBus.master)
   );

   instructionMemory memUnit (
      .clk (clk),
      .rst (rst),
      .mem (memBus.slave)
   );

   // Fetch-to-decode register.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         InstrD   <= '0;
         PCD      <= fetchPkg::PC_INITIAL;
         PCPlus4D <= fetchPkg::PC_INITIAL + fetchPkg::wordT'(4);
         ValidD   <= 1'b0;
      end else if (FlushD) begin
         InstrD <= fetchPkg::NOP_INSTR;
         ValidD <= 1'b0;
      end else if (StallD) begin
         // Decode holds its word.
         InstrD <= InstrD;
      end else if (CacheStall) begin
         // Bubble while the cache is busy.
         InstrD <= fetchPkg::NOP_INSTR;
         ValidD <= 1'b0;
      end else begin
         InstrD   <= InstrF;
         PCD      <= PCF;
         PCPlus4D <= PCPlus4F;
         ValidD   <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== instructionMemory.sv ====
`default_nettype none

module instructionMemory (
   input  wire logic clk,
   input  wire logic rst,
   memReadIf.slave   mem
);

   fetchPkg::wordT     words [fetchPkg::IMEM_WORDS];
   fetchPkg::imemAddrT baseIdx;
   fetchPkg::latCountT count;
   logic               busy;
   logic               accept;
   logic               done;

   initial begin
      $readmemh("imem.hex", words);
   end

   // Only one request is ever outstanding.
   assign accept = mem.memRead && !busy;
   assign done   = busy && (count == '0);

   // Counts so that ready lands MEM_LATENCY cycles after the request cycle.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy         <= 1'b0;
         count        <= '0;
         mem.memReady <= 1'b0;
      end else begin
         mem.memReady <= 1'b0;
         if (accept) begin
            busy  <= 1'b1;
            count <= fetchPkg::latCountT'(fetchPkg::MEM_LATENCY - 2);
         end else if (done) begin
            busy         <= 1'b0;
            mem.memReady <= 1'b1;
         end else if (busy) begin
            count <= count - 1'b1;
         end
      end
   end

   // Word index of the line base, wrapping at the memory depth.
   always_ff @(posedge clk) begin
      if (accept) begin
         baseIdx <= mem.memAddr[fetchPkg::BYTE_BITS +: fetchPkg::IMEM_ADDR_BITS];
      end
   end

   // Word 0 of the line sits in the low bits.
   always_ff @(posedge clk) begin
      if (done) begin
         for (int i = 0; i < fetchPkg::LINE_WORDS; i++) begin
            mem.memLine[i*fetchPkg::WORD_SIZE +: fetchPkg::WORD_SIZE] <=
               words[fetchPkg::imemAddrT'(baseIdx + i)];
         end
      end
   end

endmodule

`default_nettype wire

// ==== iCache.sv ====
`default_nettype none

module iCache (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire fetchPkg::wordT pc,
   output fetchPkg::wordT      instr,
   output logic                stall,
   memReadIf.master            mem
);

   // Address fields of the current PC.
   fetchPkg::tagT    pcTag;
   fetchPkg::indexT  pcIndex;
   fetchPkg::offsetT pcOffset;

   // Storage.
   fetchPkg::lineT   lineData [fetchPkg::CACHE_LINES];
   fetchPkg::tagT    tagStore [fetchPkg::CACHE_LINES];
   logic [fetchPkg::CACHE_LINES-1:0] validBits;

   // Refill control.
   fetchPkg::cacheStateT state;
   logic                 hit;
   logic                 readPulse;
   fetchPkg::wordT       refillAddr;
   fetchPkg::tagT        refillTag;
   fetchPkg::indexT      refillIndex;

   assign pcOffset = pc[fetchPkg::BYTE_BITS +: fetchPkg::OFFSET_BITS];
   assign pcIndex  = pc[fetchPkg::LINE_BITS +: fetchPkg::INDEX_BITS];
   assign pcTag    = pc[fetchPkg::WORD_SIZE-1 -: fetchPkg::TAG_BITS];

   // The refill target is fixed by the latched address, not the live PC.
   assign refillIndex = refillAddr[fetchPkg::LINE_BITS +: fetchPkg::INDEX_BITS];
   assign refillTag   = refillAddr[fetchPkg::WORD_SIZE-1 -: fetchPkg::TAG_BITS];

   assign hit   = validBits[pcIndex] && (tagStore[pcIndex] == pcTag);
   assign instr = lineData[pcIndex][pcOffset*fetchPkg::WORD_SIZE +: fetchPkg::WORD_SIZE];

   // Stall on a miss and for the whole refill.
   assign stall = (state != fetchPkg::IDLE) || !hit;

   assign mem.memAddr = refillAddr;
   assign mem.memRead = readPulse;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= fetchPkg::IDLE;
         readPulse <= 1'b0;
         validBits <= '0;
      end else begin
         readPulse <= 1'b0;
         case (state)
            fetchPkg::IDLE: begin
               if (!hit) begin
                  state     <= fetchPkg::REFILL;
                  readPulse <= 1'b1;
               end
            end
            fetchPkg::REFILL: begin
               if (mem.memReady) begin
                  validBits[refillIndex] <= 1'b1;
                  state                  <= fetchPkg::IDLE;
               end
            end
            default: begin
               state <= fetchPkg::IDLE;
            end
         endcase
      end
   end

   // Line-aligned miss address, captured as the request goes out.
   always_ff @(posedge clk) begin
      if (state == fetchPkg::IDLE && !hit) begin
         refillAddr <= {pc[fetchPkg::WORD_SIZE-1:fetchPkg::LINE_BITS],
                        {fetchPkg::LINE_BITS{1'b0}}};
      end
   end

   // Line and tag written at the ready edge.
   always_ff @(posedge clk) begin
      if (state == fetchPkg::REFILL && mem.memReady) begin
         lineData[refillIndex] <= mem.memLine;
         tagStore[refillIndex] <= refillTag;
      end
   end

endmodule

`default_nettype wire

// ==== programCounter.sv ====
`default_nettype none

module programCounter (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           hold,
   input  wire logic           redirect,
   input  wire fetchPkg::wordT target,
   output fetchPkg::wordT      pc,
   output fetchPkg::wordT      pcPlus4
);

   fetchPkg::wordT pcNext;

   assign pcPlus4 = pc + fetchPkg::wordT'(4);

   // A redirect wins over any stall.
   always_comb begin
      if (redirect) begin
         pcNext = target;
      end else if (hold) begin
         pcNext = pc;
      end else begin
         pcNext = pcPlus4;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pc <= fetchPkg::PC_INITIAL;
      end else begin
         pc <= pcNext;
      end
   end

endmodule

`default_nettype wire

// ==== memReadIf.sv ====
`default_nettype none

interface memReadIf;

   // Line-aligned byte address and one-cycle request.
   fetchPkg::wordT memAddr;
   logic           memRead;

   // Returned line, valid together with the ready pulse.
   fetchPkg::lineT memLine;
   logic           memReady;

   modport master (
      output memAddr,
      output memRead,
      input  memLine,
      input  memReady
   );

   modport slave (
      input  memAddr,
      input  memRead,
      output memLine,
      output memReady
   );

endinterface

`default_nettype wire

// ==== fetchPkg.sv ====
`default_nettype none

package fetchPkg;

   // Datapath widths.
   localparam int WORD_SIZE  = 32;
   localparam int LINE_WORDS = 4;

   // Cache geometry.
   localparam int CACHE_LINES = 4;
   localparam int BYTE_BITS   = 2;
   localparam int OFFSET_BITS = $clog2(LINE_WORDS);
   localparam int INDEX_BITS  = $clog2(CACHE_LINES);
   localparam int LINE_BITS   = OFFSET_BITS + BYTE_BITS;
   localparam int TAG_BITS    = WORD_SIZE - INDEX_BITS - LINE_BITS;

   // Instruction memory; addresses wrap at 256 bytes.
   localparam int IMEM_WORDS     = 64;
   localparam int IMEM_ADDR_BITS = $clog2(IMEM_WORDS);
   localparam int MEM_LATENCY    = 4;
   localparam int LAT_BITS       = $clog2(MEM_LATENCY);

   localparam logic [WORD_SIZE-1:0] PC_INITIAL = 32'h0000_0000;
   // addi x0, x0, 0.
   localparam logic [WORD_SIZE-1:0] NOP_INSTR  = 32'h0000_0013;

   typedef logic [WORD_SIZE-1:0]            wordT;
   typedef logic [LINE_WORDS*WORD_SIZE-1:0] lineT;
   typedef logic [TAG_BITS-1:0]             tagT;
   typedef logic [INDEX_BITS-1:0]           indexT;
   typedef logic [OFFSET_BITS-1:0]          offsetT;
   typedef logic [IMEM_ADDR_BITS-1:0]       imemAddrT;
   typedef logic [LAT_BITS-1:0]             latCountT;

   typedef enum logic {
      IDLE,
      REFILL
   } cacheStateT;

endpackage

`default_nettype wire
